//--- filelist.f
+incdir+test
source/switch_pkg.sv
source/ingress_arbiter.sv
source/slot_allocator.sv
source/packet_buffer.sv
source/priority_dispatch.sv
source/output_queue.sv
source/egress_scheduler.sv
source/switch_top.sv
test/switch_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module switch_tb -f filelist.f -o switch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/switch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- source/egress_scheduler.sv
`timescale 1ns/1ps

module egress_scheduler import switch_pkg::*; #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             ready,
    input  logic [NUM_PORTS-1:0]             nonempty,
    input  slot_t [NUM_PORTS-1:0]            head_slot,
    input  len_t                             rd_len,
    input  logic [DATA_W-1:0]                rd_data_in,
    output logic [NUM_PORTS-1:0]             deq,
    output slot_t                            rd_slot,
    output word_idx_t                        rd_idx,
    output logic                             free,
    output slot_t                            free_slot,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data
);

    egress_state_t        state;
    port_t                port_q;
    slot_t                slot_q;
    word_idx_t            idx_q;
    logic [NUM_PORTS-1:0] cand;
    logic                 win_vld;
    port_t                win;
    logic                 pick;
    logic                 rd;
    logic                 last_word;

    // a port is eligible with a queued packet and its sink ready
    assign cand = nonempty & ready;

    always_comb begin
        win_vld = 1'b0;
        win     = port_q;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            if (cand[(int'(port_q) + i) % NUM_PORTS]) begin
                win_vld = 1'b1;
                win     = port_t'((int'(port_q) + i) % NUM_PORTS);
            end
        end
    end

    assign pick      = state == EG_IDLE && win_vld;
    assign rd        = state == EG_STREAM && ready[port_q];
    assign last_word = len_t'(idx_q) + len_t'(1) == rd_len;

    always_comb begin
        deq = '0;
        if (pick) begin
            deq[win] = 1'b1;
        end
    end

    assign rd_slot   = slot_q;
    assign rd_idx    = idx_q;
    assign free      = rd && last_word;
    assign free_slot = slot_q;

    // buffer data arrives together with the registered flags
    assign rd_data = {NUM_PORTS{rd_data_in}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= EG_IDLE;
            port_q <= port_t'(NUM_PORTS - 1);
            idx_q  <= '0;
            rd_vld <= '0;
            rd_sop <= '0;
            rd_eop <= '0;
        end else begin
            rd_vld <= '0;
            rd_sop <= '0;
            rd_eop <= '0;
            case (state)
                EG_IDLE: begin
                    if (win_vld) begin
                        port_q <= win;
                        idx_q  <= '0;
                        state  <= EG_STREAM;
                    end
                end
                EG_STREAM: begin
                    // no read while the sink holds ready low
                    if (rd) begin
                        rd_vld[port_q] <= 1'b1;
                        rd_sop[port_q] <= idx_q == '0;
                        rd_eop[port_q] <= last_word;
                        idx_q          <= idx_q + 1'b1;
                        if (last_word) begin
                            state <= EG_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pick) begin
            slot_q <= head_slot[win];
        end
    end

endmodule

//--- source/ingress_arbiter.sv
`timescale 1ns/1ps

module ingress_arbiter import switch_pkg::*; #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             wr_sop,
    input  logic [NUM_PORTS-1:0]             wr_eop,
    input  logic [NUM_PORTS-1:0]             wr_vld,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data,
    input  logic                             slot_avail,
    input  slot_t                            slot,
    output logic [NUM_PORTS-1:0]             pause,
    output logic                             alloc,
    output wr_word_t                         wr_word,
    output logic                             wr_len_en,
    output len_t                             wr_len,
    output enq_t                             enq
);

    logic                 busy;
    logic                 just_done;
    port_t                grant;
    slot_t                slot_q;
    hdr_t                 hdr_q;
    word_idx_t            idx_q;
    logic [NUM_PORTS-1:0] req;
    logic                 win_vld;
    port_t                win;
    port_t                cur;
    logic                 take;
    logic                 last;
    slot_t                cur_slot;
    word_idx_t            cur_idx;
    hdr_t                 sop_hdr;
    hdr_t                 cur_hdr;

    // sop requests, the port that just finished sits out one cycle
    always_comb begin
        req = wr_vld & wr_sop;
        if (just_done) begin
            req[grant] = 1'b0;
        end
    end

    // round robin, search starts right after the last grant
    always_comb begin
        win_vld = 1'b0;
        win     = grant;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            if (req[(int'(grant) + i) % NUM_PORTS]) begin
                win_vld = 1'b1;
                win     = port_t'((int'(grant) + i) % NUM_PORTS);
            end
        end
    end

    assign alloc = !busy && win_vld && slot_avail;
    assign cur   = busy ? grant : win;
    assign take  = busy ? wr_vld[grant] : alloc;
    assign last  = take && wr_eop[cur];

    assign sop_hdr.dest = wr_data[win][HDR_DEST_LSB +: $bits(port_t)];
    assign sop_hdr.prio = wr_data[win][HDR_PRIO_LSB +: $bits(prio_t)];

    assign cur_slot = busy ? slot_q : slot;
    assign cur_idx  = busy ? idx_q : '0;
    assign cur_hdr  = busy ? hdr_q : sop_hdr;

    always_comb begin
        pause = '1;
        if (busy) begin
            pause[grant] = 1'b0;
        end else if (alloc) begin
            pause[win] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            just_done <= 1'b0;
            grant     <= port_t'(NUM_PORTS - 1);
        end else begin
            just_done <= last;
            if (alloc) begin
                grant <= win;
                // single word packets never hold the grant
                busy  <= !wr_eop[win];
            end else if (last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_q <= slot;
            hdr_q  <= sop_hdr;
        end
        if (take) begin
            idx_q <= cur_idx + 1'b1;
        end
    end

    // buffer write and enqueue land one cycle after the word is taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_word   <= '0;
            wr_len_en <= 1'b0;
            enq       <= '0;
        end else begin
            wr_len_en <= last;
            enq.valid <= last;
            if (take) begin
                wr_word.slot <= cur_slot;
                wr_word.idx  <= cur_idx;
                wr_word.data <= wr_data[cur];
                enq.dest     <= cur_hdr.dest;
                enq.prio     <= cur_hdr.prio;
                enq.slot     <= cur_slot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_len <= len_t'(cur_idx) + len_t'(1);
        end
    end

endmodule

//--- source/output_queue.sv
`timescale 1ns/1ps

module output_queue import switch_pkg::*; #(
    parameter port_t PORT_ID = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wrr_en,
    input  enq_t  enq,
    input  logic  deq,
    output logic  nonempty,
    output slot_t head_slot
);

    localparam int PTR_W = $clog2(NUM_SLOTS);

    typedef logic [PTR_W:0] cnt_t;

    slot_t                fifo [NUM_PRIOS][NUM_SLOTS];
    logic [PTR_W-1:0]     head [NUM_PRIOS];
    logic [PTR_W-1:0]     tail [NUM_PRIOS];
    cnt_t                 count [NUM_PRIOS];
    logic [NUM_PRIOS-1:0] q_nonempty;
    logic [NUM_PRIOS-1:0] push_vec;
    logic [NUM_PRIOS-1:0] pop_vec;
    logic                 push;
    prio_t                sel;

    // enqueue is broadcast, only the addressed port takes it
    assign push = enq.valid && enq.dest == PORT_ID;

    always_comb begin
        push_vec = '0;
        pop_vec  = '0;
        push_vec[enq.prio] = push;
        pop_vec[sel]       = deq;
        for (int p = 0; p < NUM_PRIOS; p++) begin
            q_nonempty[p] = count[p] != '0;
        end
    end

    assign nonempty  = |q_nonempty;
    assign head_slot = fifo[sel][head[sel]];

    priority_dispatch i_priority_dispatch (
        .clk,
        .rst_n,
        .wrr_en,
        .queue_nonempty (q_nonempty),
        .served         (deq),
        .prio           (sel)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PRIOS; p++) begin
                head[p]  <= '0;
                tail[p]  <= '0;
                count[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PRIOS; p++) begin
                if (push_vec[p]) begin
                    tail[p] <= tail[p] + 1'b1;
                end
                if (pop_vec[p]) begin
                    head[p] <= head[p] + 1'b1;
                end
                count[p] <= count[p] + cnt_t'(push_vec[p]) - cnt_t'(pop_vec[p]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[enq.prio][tail[enq.prio]] <= enq.slot;
        end
    end

endmodule

//--- source/packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer import switch_pkg::*; #(
    parameter int NUM_SLOTS = switch_pkg::NUM_SLOTS
) (
    input  logic              clk,
    input  wr_word_t          wr_word,
    input  logic              wr_len_en,
    input  len_t              wr_len,
    input  slot_t             wr_len_slot,
    input  slot_t             rd_slot,
    input  word_idx_t         rd_idx,
    output logic [DATA_W-1:0] rd_data,
    output len_t              rd_len
);

    logic [DATA_W-1:0] mem [NUM_SLOTS][MAX_PKT_WORDS];
    len_t              len_tab [NUM_SLOTS];

    // the held word is rewritten until the next one is taken
    always_ff @(posedge clk) begin
        mem[wr_word.slot][wr_word.idx] <= wr_word.data;
    end

    always_ff @(posedge clk) begin
        if (wr_len_en) begin
            len_tab[wr_len_slot] <= wr_len;
        end
    end

    // single read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_slot][rd_idx];
    end

    assign rd_len = len_tab[rd_slot];

endmodule

//--- source/priority_dispatch.sv
`timescale 1ns/1ps

module priority_dispatch import switch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wrr_en,
    input  logic [NUM_PRIOS-1:0] queue_nonempty,
    input  logic                 served,
    output prio_t                prio
);

    prio_t last_served;

    always_comb begin
        prio = '0;
        if (wrr_en) begin
            // first nonempty after the last served, wrapping
            for (int i = NUM_PRIOS; i >= 1; i--) begin
                if (queue_nonempty[(int'(last_served) + i) % NUM_PRIOS]) begin
                    prio = prio_t'((int'(last_served) + i) % NUM_PRIOS);
                end
            end
        end else begin
            // strict, highest number wins
            for (int i = 0; i < NUM_PRIOS; i++) begin
                if (queue_nonempty[i]) begin
                    prio = prio_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_served <= prio_t'(NUM_PRIOS - 1);
        end else if (served) begin
            last_served <= prio;
        end
    end

endmodule

//--- source/slot_allocator.sv
`timescale 1ns/1ps

module slot_allocator import switch_pkg::*; #(
    parameter int NUM_SLOTS = switch_pkg::NUM_SLOTS
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  alloc,
    input  logic  free,
    input  slot_t free_slot,
    output logic  slot_avail,
    output slot_t slot
);

    // pointers wrap naturally, NUM_SLOTS is a power of two
    localparam int PTR_W = $clog2(NUM_SLOTS);

    typedef logic [PTR_W:0] cnt_t;

    slot_t            fifo [NUM_SLOTS];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    cnt_t             count;

    assign slot_avail = count != '0;
    assign slot       = fifo[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= cnt_t'(NUM_SLOTS);
            // every slot starts out free
            for (int i = 0; i < NUM_SLOTS; i++) begin
                fifo[i] <= slot_t'(i);
            end
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (free) begin
                fifo[tail] <= free_slot;
                tail       <= tail + 1'b1;
            end
            count <= count + cnt_t'(free) - cnt_t'(alloc);
        end
    end

endmodule

//--- source/switch_pkg.sv
package switch_pkg;

    // switch sizes
    localparam int NUM_PORTS     = 4;
    localparam int NUM_PRIOS     = 8;
    localparam int NUM_SLOTS     = 16;
    localparam int MAX_PKT_WORDS = 16;
    localparam int DATA_W        = 16;

    // header word field positions
    localparam int HDR_DEST_LSB = 0;
    localparam int HDR_PRIO_LSB = 4;

    typedef logic [1:0] port_t;
    typedef logic [2:0] prio_t;
    typedef logic [3:0] slot_t;
    typedef logic [3:0] word_idx_t;
    // length 1 to 16 needs the extra bit
    typedef logic [4:0] len_t;

    typedef struct packed {
        port_t dest;
        prio_t prio;
    } hdr_t;

    typedef struct packed {
        slot_t             slot;
        word_idx_t         idx;
        logic [DATA_W-1:0] data;
    } wr_word_t;

    typedef struct packed {
        logic  valid;
        port_t dest;
        prio_t prio;
        slot_t slot;
    } enq_t;

    typedef enum logic {
        EG_IDLE,
        EG_STREAM
    } egress_state_t;

endpackage

//--- source/switch_top.sv
`timescale 1ns/1ps

module switch_top import switch_pkg::*; #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             wr_sop,
    input  logic [NUM_PORTS-1:0]             wr_eop,
    input  logic [NUM_PORTS-1:0]             wr_vld,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data,
    output logic [NUM_PORTS-1:0]             pause,
    input  logic [NUM_PORTS-1:0]             ready,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data,
    input  logic [NUM_PORTS-1:0]             wrr_enable
);

    logic                  slot_avail;
    logic                  alloc;
    slot_t                 slot;
    wr_word_t              wr_word;
    logic                  wr_len_en;
    len_t                  wr_len;
    enq_t                  enq;
    slot_t                 rd_slot;
    word_idx_t             rd_idx;
    len_t                  rd_len;
    logic [DATA_W-1:0]     buf_rd_data;
    logic                  free;
    slot_t                 free_slot;
    logic [NUM_PORTS-1:0]  nonempty;
    slot_t [NUM_PORTS-1:0] head_slot;
    logic [NUM_PORTS-1:0]  deq;

    ingress_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) i_ingress_arbiter (
        .clk,
        .rst_n,
        .wr_sop,
        .wr_eop,
        .wr_vld,
        .wr_data,
        .slot_avail,
        .slot,
        .pause,
        .alloc,
        .wr_word,
        .wr_len_en,
        .wr_len,
        .enq
    );

    slot_allocator #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_slot_allocator (
        .clk,
        .rst_n,
        .alloc,
        .free,
        .free_slot,
        .slot_avail,
        .slot
    );

    // length is stored against the slot carried by the enqueue entry
    packet_buffer #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_packet_buffer (
        .clk,
        .wr_word,
        .wr_len_en,
        .wr_len,
        .wr_len_slot (enq.slot),
        .rd_slot,
        .rd_idx,
        .rd_data     (buf_rd_data),
        .rd_len
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        output_queue #(
            .PORT_ID (port_t'(p))
        ) i_output_queue (
            .clk,
            .rst_n,
            .wrr_en    (wrr_enable[p]),
            .enq,
            .deq       (deq[p]),
            .nonempty  (nonempty[p]),
            .head_slot (head_slot[p])
        );
    end

    egress_scheduler #(
        .NUM_PORTS (NUM_PORTS)
    ) i_egress_scheduler (
        .clk,
        .rst_n,
        .ready,
        .nonempty,
        .head_slot,
        .rd_len,
        .rd_data_in (buf_rd_data),
        .deq,
        .rd_slot,
        .rd_idx,
        .free,
        .free_slot,
        .rd_sop,
        .rd_eop,
        .rd_vld,
        .rd_data
    );

endmodule

//--- test/switch_tb_tasks.svh
// xorshift32
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
endfunction

task automatic report_error(input string msg);
    $display("error in %s: %s", cur_test, msg);
    err_count++;
endtask

task automatic compare_word(input string what, input logic [DATA_W-1:0] exp_val,
                            input logic [DATA_W-1:0] act_val);
    if (act_val !== exp_val) begin
        $display("Mismatch in %s, %s: expected %h, actual %h",
                 cur_test, what, exp_val, act_val);
        err_count++;
    end
endtask

task automatic compare_prio(input string what, input prio_t exp_val, input prio_t act_val);
    if (act_val !== exp_val) begin
        $display("Mismatch in %s, %s: expected %0d, actual %0d",
                 cur_test, what, exp_val, act_val);
        err_count++;
    end
endtask

task automatic compare_count(input string what, input len_t exp_val, input len_t act_val);
    if (act_val !== exp_val) begin
        $display("Mismatch in %s, %s: expected %0d, actual %0d",
                 cur_test, what, exp_val, act_val);
        err_count++;
    end
endtask

task automatic clear_scoreboard();
    rx_total = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
        rx_cnt[p]  = 0;
        rx_busy[p] = 1'b0;
        rx_prio[p].delete();
        src_ids[p].delete();
        for (int d = 0; d < NUM_PORTS; d++) begin
            for (int q = 0; q < NUM_PRIOS; q++) begin
                last_id[p][d][q] = -1;
            end
        end
    end
endtask

task automatic reset_dut();
    @(negedge clk);
    rst_n      = 1'b0;
    wr_sop     = '0;
    wr_eop     = '0;
    wr_vld     = '0;
    wr_data    = '0;
    ready      = '0;
    wrr_enable = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    if (rd_vld !== '0 || rd_sop !== '0 || rd_eop !== '0) begin
        report_error("read outputs are not idle during reset");
    end
    clear_scoreboard();
    rst_n = 1'b1;
endtask

task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
    reset_dut();
endtask

task automatic finish_test();
    tests_run++;
    if (err_count == test_err_base) begin
        $display("test %0d %s: ok", tests_run, cur_test);
    end else begin
        tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, cur_test, err_count - test_err_base);
    end
endtask

// word 0 is the header, word 1 the tag {src, dest, id}
task automatic build_packet(input port_t src, input port_t dest, input prio_t prio,
                            input len_t len, output int id);
    logic [31:0]       r;
    logic [DATA_W-1:0] hdr;
    id = next_id;
    next_id++;
    r   = next_rand();
    hdr = r[DATA_W-1:0];
    hdr[HDR_DEST_LSB +: $bits(port_t)] = dest;
    hdr[HDR_PRIO_LSB +: $bits(prio_t)] = prio;
    exp_words[id][0] = hdr;
    exp_words[id][1] = {4'(src), 4'(dest), 8'(id)};
    for (int w = 2; w < int'(len); w++) begin
        r = next_rand();
        exp_words[id][w] = r[DATA_W-1:0];
    end
    exp_len[id]  = len;
    exp_src[id]  = src;
    exp_dst[id]  = dest;
    exp_prio[id] = prio;
endtask

// 2 to 16 words, random destination
task automatic random_packet(input port_t src, input prio_t prio, output int id);
    logic [31:0] r;
    r = next_rand();
    build_packet(src, port_t'(r[17:16]), prio, len_t'(2 + r % 15), id);
endtask

// a word counts as taken when pause is low just before the rising edge
task automatic send_packet(input port_t src, input int id);
    int w;
    w = 0;
    while (w < int'(exp_len[id])) begin
        @(negedge clk);
        wr_vld[src]  = 1'b1;
        wr_sop[src]  = w == 0;
        wr_eop[src]  = w == int'(exp_len[id]) - 1;
        wr_data[src] = exp_words[id][w];
        #(CLK_HALF - 1);
        if (!pause[src]) begin
            w++;
        end
    end
    @(negedge clk);
    wr_vld[src] = 1'b0;
    wr_sop[src] = 1'b0;
    wr_eop[src] = 1'b0;
endtask

task automatic send_list(input port_t src);
    int id;
    while (src_ids[src].size() > 0) begin
        id = src_ids[src].pop_front();
        send_packet(src, id);
    end
endtask

task automatic toggle_ready(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
        @(negedge clk);
        r     = next_rand();
        ready = r[NUM_PORTS-1:0];
    end
    @(negedge clk);
    ready = '1;
endtask

task automatic wait_for_rx(input int n);
    while (rx_total < n) begin
        @(negedge clk);
    end
endtask

task automatic check_packet(input int p);
    int    id;
    prio_t rp;
    id = int'(rx_words[p][1][7:0]);
    rp = rx_words[p][0][HDR_PRIO_LSB +: $bits(prio_t)];
    rx_prio[p].push_back(rp);
    rx_total++;
    if (rx_cnt[p] < 2 || id >= next_id) begin
        report_error($sformatf("packet on port %0d carries no valid tag", p));
    end else begin
        compare_count($sformatf("length of packet %0d", id), exp_len[id], len_t'(rx_cnt[p]));
        for (int w = 0; w < rx_cnt[p] && w < int'(exp_len[id]); w++) begin
            compare_word($sformatf("word %0d of packet %0d", w, id),
                         exp_words[id][w], rx_words[p][w]);
        end
        if (exp_dst[id] != port_t'(p)) begin
            report_error($sformatf("packet %0d for port %0d came out of port %0d",
                                   id, exp_dst[id], p));
        end
        // same source, destination and priority keep their order
        if (id <= last_id[exp_src[id]][p][exp_prio[id]]) begin
            report_error($sformatf("packet %0d from port %0d arrived out of order",
                                   id, exp_src[id]));
        end else begin
            last_id[exp_src[id]][p][exp_prio[id]] = id;
        end
    end
endtask

task automatic collect_word(input int p, input logic sop, input logic eop,
                            input logic [DATA_W-1:0] data);
    if (sop && rx_busy[p]) begin
        report_error($sformatf("rd_sop inside a packet on port %0d", p));
    end else if (!sop && !rx_busy[p]) begin
        report_error($sformatf("word without rd_sop on port %0d", p));
    end
    if (sop) begin
        rx_busy[p] = 1'b1;
        rx_cnt[p]  = 0;
    end
    if (rx_cnt[p] < MAX_PKT_WORDS) begin
        rx_words[p][rx_cnt[p]] = data;
    end else begin
        report_error($sformatf("packet longer than %0d words on port %0d", MAX_PKT_WORDS, p));
    end
    rx_cnt[p]++;
    if (eop) begin
        rx_busy[p] = 1'b0;
        check_packet(p);
    end
endtask

task automatic check_order(input int p, input int n, input prio_t order [4]);
    compare_count("packets delivered", len_t'(n), len_t'(rx_prio[p].size()));
    for (int i = 0; i < n && i < rx_prio[p].size(); i++) begin
        compare_prio($sformatf("priority of arrival %0d", i), order[i], rx_prio[p][i]);
    end
endtask

task automatic test_single_packet();
    int id;
    start_test("single packet");
    ready = '1;
    build_packet(port_t'(0), port_t'(2), prio_t'(0), len_t'(5), id);
    send_packet(port_t'(0), id);
    wait_for_rx(1);
    // room for a stray word on another port
    repeat (4) @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
        compare_count($sformatf("packets on port %0d", p), len_t'(p == 2 ? 1 : 0),
                      len_t'(rx_prio[p].size()));
    end
    finish_test();
endtask

// port 1 held back until every packet is queued
task automatic run_priority_test(input string name, input logic wrr, input int n,
                                 input prio_t sent [4], input prio_t expected [4]);
    int id;
    start_test(name);
    ready         = '1;
    ready[1]      = 1'b0;
    wrr_enable[1] = wrr;
    for (int i = 0; i < n; i++) begin
        build_packet(port_t'(0), port_t'(1), sent[i], len_t'(3 + i), id);
        send_packet(port_t'(0), id);
    end
    repeat (ENQ_LATENCY + 1) @(negedge clk);
    ready[1] = 1'b1;
    wait_for_rx(n);
    check_order(1, n, expected);
    finish_test();
endtask

task automatic test_strict_priority();
    prio_t sent [4];
    prio_t expected [4];
    sent     = '{3'd1, 3'd5, 3'd3, 3'd0};
    expected = '{3'd5, 3'd3, 3'd1, 3'd0};
    run_priority_test("strict priority", 1'b0, 3, sent, expected);
endtask

task automatic test_round_robin();
    prio_t sent [4];
    prio_t expected [4];
    sent     = '{3'd1, 3'd1, 3'd5, 3'd5};
    expected = '{3'd1, 3'd5, 3'd1, 3'd5};
    run_priority_test("round robin", 1'b1, 4, sent, expected);
endtask

task automatic test_contention();
    int id;
    start_test("contention");
    ready = '1;
    for (int s = 0; s < NUM_PORTS; s++) begin
        for (int k = 0; k < PKTS_PER_SRC; k++) begin
            random_packet(port_t'(s), prio_t'(2), id);
            src_ids[s].push_back(id);
        end
    end
    fork
        send_list(port_t'(0));
        send_list(port_t'(1));
        send_list(port_t'(2));
        send_list(port_t'(3));
    join
    wait_for_rx(NUM_PORTS * PKTS_PER_SRC);
    finish_test();
endtask

task automatic test_back_pressure();
    int          id;
    logic [31:0] r;
    len_t        held;
    start_test("back-pressure");
    ready = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
        r = next_rand();
        build_packet(port_t'(0), port_t'(i % NUM_PORTS), prio_t'(0), len_t'(2 + r % 15), id);
        send_packet(port_t'(0), id);
    end
    // every slot is taken, this sop has to wait
    random_packet(port_t'(3), prio_t'(0), id);
    held = '0;
    @(negedge clk);
    wr_vld[3]  = 1'b1;
    wr_sop[3]  = 1'b1;
    wr_eop[3]  = 1'b0;
    wr_data[3] = exp_words[id][0];
    repeat (HOLD_CYCLES) begin
        #(CLK_HALF - 1);
        if (pause[3]) begin
            held = held + 1'b1;
        end
        @(negedge clk);
    end
    compare_count("cycles with pause high", len_t'(HOLD_CYCLES), held);
    fork
        send_packet(port_t'(3), id);
        toggle_ready(TOGGLE_CYCLES);
    join
    wait_for_rx(NUM_SLOTS + 1);
    finish_test();
endtask

//--- test/switch_tb.sv
`timescale 1ns/1ps

module switch_tb import switch_pkg::*; ();

    localparam int          CLK_HALF      = 5;
    localparam int          RESET_CYCLES  = 10;
    localparam int          ENQ_LATENCY   = 1;
    localparam int          PKTS_PER_SRC  = 6;
    localparam int          HOLD_CYCLES   = 20;
    localparam int          TOGGLE_CYCLES = 80;
    localparam int          NUM_TESTS     = 5;
    localparam int          MAX_IDS       = 256;
    localparam logic [31:0] SEED          = 32'd24310;

    // packets over all five tests
    localparam int TOTAL_PKTS = 1 + 3 + 4 + NUM_PORTS * PKTS_PER_SRC + NUM_SLOTS + 1;
    // each packet may take a few passes of 16 words through ingress and egress
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + 2)
                                  + TOTAL_PKTS * MAX_PKT_WORDS * 5
                                  + HOLD_CYCLES + TOGGLE_CYCLES;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             wr_sop;
    logic [NUM_PORTS-1:0]             wr_eop;
    logic [NUM_PORTS-1:0]             wr_vld;
    logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data;
    logic [NUM_PORTS-1:0]             pause;
    logic [NUM_PORTS-1:0]             ready;
    logic [NUM_PORTS-1:0]             rd_sop;
    logic [NUM_PORTS-1:0]             rd_eop;
    logic [NUM_PORTS-1:0]             rd_vld;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data;
    logic [NUM_PORTS-1:0]             wrr_enable;

    // sent packets by the id in their tag word
    logic [DATA_W-1:0] exp_words [MAX_IDS][MAX_PKT_WORDS];
    len_t              exp_len [MAX_IDS];
    port_t             exp_src [MAX_IDS];
    port_t             exp_dst [MAX_IDS];
    prio_t             exp_prio [MAX_IDS];
    int                next_id = 0;
    int                src_ids [NUM_PORTS][$];

    // receive side
    logic [DATA_W-1:0]    rx_words [NUM_PORTS][MAX_PKT_WORDS];
    int                   rx_cnt [NUM_PORTS];
    logic                 rx_busy [NUM_PORTS];
    prio_t                rx_prio [NUM_PORTS][$];
    int                   rx_total = 0;
    int                   last_id [NUM_PORTS][NUM_PORTS][NUM_PRIOS];
    logic [NUM_PORTS-1:0] ready_q;

    logic [31:0] rand_state;
    string       cur_test;
    int          err_count    = 0;
    int          test_err_base = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;

    switch_top #(
        .NUM_PORTS (NUM_PORTS)
    ) i_switch_top (
        .clk,
        .rst_n,
        .wr_sop,
        .wr_eop,
        .wr_vld,
        .wr_data,
        .pause,
        .ready,
        .rd_sop,
        .rd_eop,
        .rd_vld,
        .rd_data,
        .wrr_enable
    );

    `include "switch_tb_tasks.svh"

    always #CLK_HALF clk = ~clk;

    // ready as the DUT saw it at the last rising edge
    always @(posedge clk) begin
        ready_q <= ready;
    end

    // registered outputs sampled at the falling edge
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rd_vld[p] === 1'b1) begin
                // a word only follows a read with ready high
                if (ready_q[p] !== 1'b1) begin
                    report_error($sformatf("word on port %0d although ready was low", p));
                end
                collect_word(p, rd_sop[p], rd_eop[p], rd_data[p]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("error: run stopped after %0d cycles, test %s did not finish",
                     cycle_count, cur_test);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        ready      = '0;
        wrr_enable = '0;
        rand_state = SEED;
        cur_test   = "startup";

        test_single_packet();
        test_strict_priority();
        test_round_robin();
        test_contention();
        test_back_pressure();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
